// ==== hw/boot_rom.hex ====
f3
31
00
f0
3e
04
d3
f1
db
f0
e6
40
28
fa
3e
00
d3
f1
21
00
80
06
10
db
f0
77
23
10
fa
db
fe
c7

// ==== tb/z80_glue_trace.txt ====
# kind addr wdata pads drive dout gpio
# kind M mem read  W mem write  I io read  O io write  E end of trace
# pads {sd_miso sd_det up dn lt rt fire btn2} used on I lines  dout checked when drive is 1
M 00000 00 00 1 f3 00
M 00001 00 00 1 31 00
M 0001f 00 00 1 c7 00
M 00005 00 00 1 04 00
M 00fe3 00 00 1 f0 00
M 01000 00 00 0 00 00
W 00003 55 00 0 00 00
O 000f1 a5 00 0 00 a5
I 000f0 00 c0 1 c0 a5
I 000f0 00 3f 1 00 a5
I 000a8 00 2a 1 8f a5
I 000a9 00 15 1 7a a5
I 000a8 00 00 1 0a a5
I 000a9 00 ff 1 ff a5
O 000f1 06 00 0 00 06
O 000f2 77 00 0 00 06
I 00042 00 ff 0 00 06
I 000f1 00 ff 0 00 06
M 00000 00 00 1 f3 06
I 000fe 00 00 0 00 06
M 00000 00 00 0 00 06
M 0001f 00 00 0 00 06
I 000f0 00 80 1 80 06
O 000f1 f8 00 0 00 f8
W 00000 12 00 0 00 f8
E

// ==== verilog.f ====
hw/z80_glue_pkg.sv
hw/io_cycle_fsm.sv
hw/io_port_regs.sv
hw/boot_rom.sv
hw/bus_read_mux.sv
hw/z80_glue_top.sv
tb/tb_z80_glue.sv

// ==== Makefile ====
TOP = tb_z80_glue

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f verilog.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== tb/tb_z80_glue.sv ====
`timescale 1ns/1ps

module tb_z80_glue;

    localparam int HOLD_CYCLES   = 4;       // strobes held per bus cycle
    localparam int RESET_CYCLES  = 5;
    localparam int RESET_TIMEOUT = 20;      // clocks allowed for reset_n to lift

    logic                  phi, s1_n, d_drive;
    logic                  mreq_n, iorq_n, rd_n, wr_n, m1_n;
    logic                  sd_mosi, sd_clk, sd_ssel_n;
    logic                  ce_n, oe_n, we_n, reset_n;
    logic [7:0]            led;
    z80_glue_pkg::addr_t   a;
    z80_glue_pkg::data_t   d_in, d_out;
    z80_glue_pkg::pad_in_t pads;            // board inputs as driven on the pins
    integer                seed;
    integer                fd;
    int                    entries;         // bus cycles played from the trace

    z80_glue_top u_z80_glue_top (
        .phi(phi), .s1_n(s1_n), .a(a), .d_in(d_in), .d_out(d_out), .d_drive(d_drive),
        .mreq_n(mreq_n), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n), .m1_n(m1_n),
        .sd_miso(pads.sd_miso), .sd_det(pads.sd_det), .joy1_up(pads.joy_up),
        .joy1_dn(pads.joy_dn), .joy1_lt(pads.joy_lt), .joy1_rt(pads.joy_rt),
        .joy1_fire(pads.joy_fire), .joy1_btn2(pads.joy_btn2),
        .sd_mosi(sd_mosi), .sd_clk(sd_clk), .sd_ssel_n(sd_ssel_n), .led(led),
        .ce_n(ce_n), .oe_n(oe_n), .we_n(we_n), .reset_n(reset_n)
    );

    initial begin
        phi = 1'b0;
        forever #5 phi = ~phi;              // 10 ns cpu clock
    end

    // **************************************************************************
    // reporting and compares
    // **************************************************************************
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_data(input string name, input z80_glue_pkg::data_t exp,
                              input z80_glue_pkg::data_t act);
        if (act !== exp)
            abort_run($sformatf("** Error %s: expected %02h, actual %02h", name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("** Error %s: expected %b, actual %b", name, exp, act));
    endtask

    task automatic check_gpio(input string name, input z80_glue_pkg::gpio_t exp,
                              input z80_glue_pkg::gpio_t act);
        if (act !== exp)
            abort_run($sformatf("** Error %s: expected %02h, actual %02h", name, exp, act));
    endtask

    // kind M W I O starts a cycle, any other kind leaves the bus idle
    task automatic drive_bus(input logic [7:0] kind, input z80_glue_pkg::addr_t addr,
                             input z80_glue_pkg::data_t wdata, input z80_glue_pkg::pad_in_t pv);
        a      = addr;
        d_in   = wdata;
        pads   = pv;
        mreq_n = !(kind == "M" || kind == "W");
        iorq_n = !(kind == "I" || kind == "O");
        rd_n   = !(kind == "M" || kind == "I");
        wr_n   = !(kind == "W" || kind == "O");
        m1_n   = 1'b1;                      // no opcode fetch or irq acknowledge
    endtask

    task automatic check_cycle(input string tag, input logic [7:0] kind, input logic exp_drive,
                               input z80_glue_pkg::data_t exp_dout,
                               input z80_glue_pkg::gpio_t exp_gpio);
        logic is_mem;
        is_mem = (kind == "M" || kind == "W");
        check_flag({tag, " d_drive"}, exp_drive, d_drive);
        if (exp_drive)
            check_data({tag, " d_out"}, exp_dout, d_out);
        check_flag({tag, " ce_n"}, !(is_mem && !exp_drive), ce_n);    // sram takes the rest
        check_flag({tag, " oe_n"}, kind != "M", oe_n);
        check_flag({tag, " we_n"}, kind != "W", we_n);
        check_gpio({tag, " gpio"}, exp_gpio, u_z80_glue_top.gpio);
        check_flag({tag, " sd_mosi"}, exp_gpio[0], sd_mosi);
        check_flag({tag, " sd_clk"}, exp_gpio[1], sd_clk);
        check_flag({tag, " sd_ssel_n"}, exp_gpio[2], sd_ssel_n);
        check_data({tag, " led"}, {!pads.sd_miso, pads.sd_det, 3'b111, ~exp_gpio[2:0]}, led);
    endtask

    // one bus cycle, 4 clocks held then 1 idle
    task automatic play_cycle(input string tag, input logic [7:0] kind,
                              input z80_glue_pkg::addr_t addr, input z80_glue_pkg::data_t wdata,
                              input z80_glue_pkg::pad_in_t tpads, input logic exp_drive,
                              input z80_glue_pkg::data_t exp_dout,
                              input z80_glue_pkg::gpio_t exp_gpio);
        int                    rnd;
        z80_glue_pkg::pad_in_t pv;
        rnd = $random(seed);
        if (kind == "I")
            pv = tpads;
        else
            pv = rnd[7:0];                  // pads only matter to port reads
        drive_bus(kind, addr, wdata, pv);
        repeat (HOLD_CYCLES) @(negedge phi);
        check_cycle(tag, kind, exp_drive, exp_dout, exp_gpio);   // last held falling edge
        drive_bus("-", '0, '0, pv);
        @(negedge phi);
    endtask

    // **************************************************************************
    // main sequence
    // **************************************************************************
    initial begin
        logic [7:0]          kind;
        logic [7:0]          t_pads;
        z80_glue_pkg::addr_t t_addr;
        z80_glue_pkg::data_t t_wdata, t_dout;
        z80_glue_pkg::gpio_t t_gpio;
        logic                t_drive;
        int                  n;
        int                  ch;
        int                  wait_cnt;
        bit                  done;

        seed    = 32'hd390eb83;
        entries = 0;
        s1_n    = 1'b0;                     // reset button held
        drive_bus("-", '0, '0, '0);
        fd = $fopen("tb/z80_glue_trace.txt", "r");
        if (fd == 0)
            abort_run("could not open the trace file tb/z80_glue_trace.txt");

        repeat (RESET_CYCLES) @(negedge phi);
        check_flag("in reset reset_n", 1'b0, reset_n);     // cpu held while the button is down
        s1_n = 1'b1;
        wait_cnt = 0;
        while (reset_n !== 1'b1) begin      // cpu reset follows the button
            if (wait_cnt == RESET_TIMEOUT)
                abort_run("reset_n did not go high after s1_n was released");
            @(negedge phi);
            wait_cnt++;
        end
        @(negedge phi);
        check_cycle("after reset", "-", 1'b0, '0, '0);

        done = 0;
        while (!done) begin
            n = $fscanf(fd, " %c", kind);
            if (n != 1)
                abort_run("the trace file ended before its E terminator line");
            if (kind == "#") begin
                ch = 0;
                while (ch != 10 && ch != -1)
                    ch = $fgetc(fd);        // skip the rest of a comment line
            end else if (kind == "E") begin
                done = 1;
            end else begin
                n = $fscanf(fd, "%h %h %h %h %h %h", t_addr, t_wdata, t_pads,
                            t_drive, t_dout, t_gpio);
                entries++;
                if (n != 6)
                    abort_run($sformatf("trace entry %0d has missing fields", entries));
                play_cycle($sformatf("entry %0d %c %05h", entries, kind, t_addr), kind,
                           t_addr, t_wdata, t_pads, t_drive, t_dout, t_gpio);
            end
        end
        $fclose(fd);

        if (entries > 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            abort_run("the trace file holds no bus cycles");
        end
    end

endmodule

// ==== hw/z80_glue_top.sv ====
`timescale 1ns/1ps

module z80_glue_top (
    input  logic                phi,        // cpu clock out
    input  logic                s1_n,       // reset button
    input  z80_glue_pkg::addr_t a,
    input  z80_glue_pkg::data_t d_in,
    output z80_glue_pkg::data_t d_out,
    output logic                d_drive,    // tri-state enable for d
    input  logic                mreq_n,
    input  logic                iorq_n,
    input  logic                rd_n,
    input  logic                wr_n,
    input  logic                m1_n,
    input  logic                sd_miso,
    input  logic                sd_det,
    input  logic                joy1_up,
    input  logic                joy1_dn,
    input  logic                joy1_lt,
    input  logic                joy1_rt,
    input  logic                joy1_fire,
    input  logic                joy1_btn2,
    output logic                sd_mosi,
    output logic                sd_clk,
    output logic                sd_ssel_n,
    output logic [7:0]          led,
    output logic                ce_n,
    output logic                oe_n,
    output logic                we_n,
    output logic                reset_n     // cpu reset
);

    logic                   reset;
    logic                   rom_sel;
    z80_glue_pkg::cpu_bus_t bus;
    z80_glue_pkg::pad_in_t  pads;
    z80_glue_pkg::io_tick_t tick;
    z80_glue_pkg::data_t    rd_data;
    z80_glue_pkg::data_t    rom_data;
    z80_glue_pkg::gpio_t    gpio;

    // **************************************************************************
    // pins to internal form
    // **************************************************************************
    assign reset   = !s1_n;
    assign reset_n = !reset;        // cpu held in reset along with the glue

    assign bus = '{a: a, iorq: !iorq_n, mreq: !mreq_n, rd: !rd_n, wr: !wr_n, m1: !m1_n};

    assign pads = '{sd_miso: sd_miso, sd_det: sd_det,
                    joy_up: joy1_up, joy_dn: joy1_dn, joy_lt: joy1_lt,
                    joy_rt: joy1_rt, joy_fire: joy1_fire, joy_btn2: joy1_btn2};

    io_cycle_fsm u_io_cycle_fsm (.phi(phi), .reset(reset), .bus(bus), .tick(tick));

    io_port_regs u_io_port_regs (
        .phi(phi), .reset(reset), .tick(tick), .bus_data(d_in), .port(bus.a[7:0]),
        .pads(pads), .rd_data(rd_data), .gpio(gpio), .rom_sel(rom_sel)
    );

    boot_rom u_boot_rom (.phi(phi), .addr(a), .data(rom_data));

    bus_read_mux u_bus_read_mux (
        .bus(bus), .rom_sel(rom_sel), .rom_data(rom_data), .rd_data(rd_data),
        .d_out(d_out), .d_drive(d_drive), .ce_n(ce_n), .oe_n(oe_n), .we_n(we_n)
    );

    // gpio bits drive the sd spi pins directly
    assign sd_mosi   = gpio[0];
    assign sd_clk    = gpio[1];
    assign sd_ssel_n = gpio[2];
    assign led       = {!sd_miso, sd_det, 3'b111, ~gpio[2:0]};  // leds are active low

endmodule

// ==== hw/bus_read_mux.sv ====
`timescale 1ns/1ps

module bus_read_mux (
    input  z80_glue_pkg::cpu_bus_t bus,
    input  logic                   rom_sel,
    input  z80_glue_pkg::data_t    rom_data,
    input  z80_glue_pkg::data_t    rd_data,
    output z80_glue_pkg::data_t    d_out,
    output logic                   d_drive,    // fpga owns the data bus
    output logic                   ce_n,       // sram chip enable
    output logic                   oe_n,
    output logic                   we_n
);

    localparam int HI_LSB = $bits(z80_glue_pkg::addr_t) - z80_glue_pkg::ROM_HI_BITS;

    logic mem_rd, mem_wr, io_rd;
    logic sel_rom, sel_gpio, sel_joy3, sel_joy4;

    // **************************************************************************
    // asynchronous cycle decode
    // **************************************************************************
    assign mem_rd = bus.mreq && bus.rd;
    assign mem_wr = bus.mreq && bus.wr;
    assign io_rd  = bus.iorq && bus.rd;

    assign sel_rom  = rom_sel && mem_rd && (bus.a[19:HI_LSB] == '0);   // bottom 4K only
    assign sel_gpio = io_rd && (bus.a[7:0] == z80_glue_pkg::PORT_GPIO_IN);
    assign sel_joy3 = io_rd && (bus.a[7:0] == z80_glue_pkg::PORT_JOY3);
    assign sel_joy4 = io_rd && (bus.a[7:0] == z80_glue_pkg::PORT_JOY4);

    // one-hot select of what goes on the bus
    always_comb begin
        d_drive = 1'b1;
        d_out   = '0;
        unique case (1'b1)
            sel_rom:                      d_out = rom_data;     // boot rom
            sel_gpio, sel_joy3, sel_joy4: d_out = rd_data;      // input port snapshot
            default:  d_drive = 1'b0;       // someone else owns the bus
        endcase
    end

    // sram gets every memory cycle the fpga does not answer
    assign ce_n = !(bus.mreq && !d_drive);
    assign oe_n = !mem_rd;
    assign we_n = !mem_wr;

endmodule

// ==== hw/boot_rom.sv ====
`timescale 1ns/1ps

module boot_rom (
    input  logic                phi,
    input  z80_glue_pkg::addr_t addr,
    output z80_glue_pkg::data_t data
);

    // **************************************************************************
    // boot image, one byte per word
    // **************************************************************************
    z80_glue_pkg::data_t mem [z80_glue_pkg::ROM_WORDS];

    logic [z80_glue_pkg::ROM_AW-1:0] word;     // word index, image repeats over 4K

    initial begin
        $readmemh("hw/boot_rom.hex", mem);     // fills block ram at configuration
    end

    assign word = addr[z80_glue_pkg::ROM_AW-1:0];

    // registered read, one phi of latency
    always_ff @(posedge phi) begin
        data <= mem[word];
    end

endmodule

// ==== hw/io_port_regs.sv ====
`timescale 1ns/1ps

module io_port_regs (
    input  logic                   phi,
    input  logic                   reset,
    input  z80_glue_pkg::io_tick_t tick,
    input  z80_glue_pkg::data_t    bus_data,   // cpu write data
    input  z80_glue_pkg::port_t    port,       // low address byte, stable during the tick
    input  z80_glue_pkg::pad_in_t  pads,
    output z80_glue_pkg::data_t    rd_data,    // snapshot for the cpu to read
    output z80_glue_pkg::gpio_t    gpio,
    output logic                   rom_sel     // boot rom mapped in
);

    z80_glue_pkg::data_t sd_byte;       // gpio input port layout
    z80_glue_pkg::data_t joy_byte;      // joystick port layout
    logic                joy_port;      // address is one of the two joystick ports

    // **************************************************************************
    // input port byte layouts
    // **************************************************************************

    // sd status in the top two bits, rest reads as zero
    assign sd_byte = {pads.sd_miso, pads.sd_det, 6'b000000};

    // bit 1 was the video irq on J3, the video chip is gone so it idles high
    assign joy_byte = {
        pads.joy_up,
        pads.joy_dn,
        pads.joy_rt,
        pads.joy_btn2,
        1'b1,               // unused, pulled up
        pads.joy_lt,
        1'b1,               // irq_n
        pads.joy_fire
    };

    assign joy_port = (port == z80_glue_pkg::PORT_JOY3) ||
                      (port == z80_glue_pkg::PORT_JOY4);

    // **************************************************************************
    // registers
    // **************************************************************************

    // gpio output latch
    always_ff @(posedge phi) begin
        if (reset)
            gpio <= '0;
        else if (tick.wr_gpio)
            gpio <= bus_data;
    end

    // input snapshot, held until the next port read
    always_ff @(posedge phi) begin
        if (reset) begin
            rd_data <= '0;
        end else if (tick.rd_gpio) begin
            rd_data <= sd_byte;
        end else if (tick.rd_joy && joy_port) begin
            rd_data <= joy_byte;    // J3 and J4 share one stick for now
        end
    end

    // boot rom is mapped from reset until the first read of port 0xfe
    always_ff @(posedge phi) begin
        if (reset)
            rom_sel <= 1'b1;
        else if (tick.rd_rom_off)
            rom_sel <= 1'b0;        // sticky, only reset maps it back
    end

endmodule

// ==== hw/io_cycle_fsm.sv ====
`timescale 1ns/1ps

module io_cycle_fsm (
    input  logic                   phi,
    input  logic                   reset,
    input  z80_glue_pkg::cpu_bus_t bus,
    output z80_glue_pkg::io_tick_t tick
);

    logic                      io_rd;      // cpu is reading a port
    logic                      io_wr;      // cpu is writing a port
    z80_glue_pkg::port_t       port;       // low address byte
    z80_glue_pkg::cyc_state_t  state;
    z80_glue_pkg::cyc_state_t  state_nx;
    z80_glue_pkg::io_tick_t    tick_nx;

    // iorq together with m1 is an interrupt acknowledge, not a port access
    assign io_rd = bus.iorq && bus.rd && !bus.m1;
    assign io_wr = bus.iorq && bus.wr && !bus.m1;
    assign port  = bus.a[7:0];

    // **************************************************************************
    // edge counter and tick decode
    // **************************************************************************
    always_comb begin
        state_nx = state;
        tick_nx  = '0;

        case (state)
            z80_glue_pkg::IDLE:  if (io_rd || io_wr) state_nx = z80_glue_pkg::FIRST;
            z80_glue_pkg::FIRST: state_nx = z80_glue_pkg::LATER;
            z80_glue_pkg::LATER: state_nx = z80_glue_pkg::LATER;   // hold until iorq drops
            default:             state_nx = z80_glue_pkg::IDLE;
        endcase
        if (!bus.iorq)
            state_nx = z80_glue_pkg::IDLE;      // end of cycle from any state

        // read data is sampled on the first edge
        if (state == z80_glue_pkg::IDLE && io_rd) begin
            tick_nx.rd_gpio    = (port == z80_glue_pkg::PORT_GPIO_IN);
            tick_nx.rd_joy     = (port == z80_glue_pkg::PORT_JOY3) ||
                                 (port == z80_glue_pkg::PORT_JOY4);
            tick_nx.rd_rom_off = (port == z80_glue_pkg::PORT_ROM_OFF);
        end

        // write data is only stable by the second edge
        if (state == z80_glue_pkg::FIRST && io_wr)
            tick_nx.wr_gpio = (port == z80_glue_pkg::PORT_GPIO_OUT);
    end

    always_ff @(posedge phi) begin
        if (reset) begin
            state <= z80_glue_pkg::IDLE;
            tick  <= '0;
        end else begin
            state <= state_nx;
            tick  <= tick_nx;       // registered, so ticks are glitch free
        end
    end

endmodule

// ==== hw/z80_glue_pkg.sv ====
package z80_glue_pkg;

    // **************************************************************************
    // widths that carry a meaning on the board
    // **************************************************************************
    typedef logic [19:0] addr_t;        // cpu address bus, 1M
    typedef logic [7:0]  data_t;        // one byte on the data bus
    typedef logic [7:0]  gpio_t;        // gpio output latch
    typedef logic [7:0]  port_t;        // i/o port number, low address byte

    // decoded i/o ports
    localparam port_t PORT_GPIO_IN  = 8'hf0;   // sd card status in
    localparam port_t PORT_GPIO_OUT = 8'hf1;   // sd spi pins + leds out
    localparam port_t PORT_ROM_OFF  = 8'hfe;   // any read here unmaps the boot rom
    localparam port_t PORT_JOY3     = 8'ha8;   // joystick J3
    localparam port_t PORT_JOY4     = 8'ha9;   // joystick J4

    // boot rom geometry
    localparam int ROM_WORDS   = 32;
    localparam int ROM_AW      = $clog2(ROM_WORDS);  // low address bits into the rom
    localparam int ROM_HI_BITS = 8;     // a[19:12] zero means the bottom 4K

    // **************************************************************************
    // grouped signals
    // **************************************************************************

    // cpu bus with the strobes already turned active high
    typedef struct packed {
        addr_t a;
        logic  iorq;
        logic  mreq;
        logic  rd;
        logic  wr;
        logic  m1;
    } cpu_bus_t;

    // one-cycle port events, at most one set per edge
    typedef struct packed {
        logic rd_gpio;      // read of PORT_GPIO_IN
        logic rd_joy;       // read of either joystick port
        logic rd_rom_off;   // read of PORT_ROM_OFF
        logic wr_gpio;      // write of PORT_GPIO_OUT
    } io_tick_t;

    // board inputs as seen on the pins
    typedef struct packed {
        logic sd_miso;
        logic sd_det;
        logic joy_up;
        logic joy_dn;
        logic joy_lt;
        logic joy_rt;
        logic joy_fire;
        logic joy_btn2;
    } pad_in_t;

    // i/o cycle edge counter
    typedef enum logic [1:0] {
        IDLE,               // no i/o cycle in progress
        FIRST,              // first phi edge of the cycle seen
        LATER               // past the second edge, wait for iorq to drop
    } cyc_state_t;

endpackage
